/* project.f */
+incdir+include
logic/zz_pkg.sv
logic/zz_row_if.sv
logic/zz_coef_store.sv
logic/zz_last_tracker.sv
logic/zz_scan_seq.sv
logic/zz_scan_top.sv
testbench/zz_scan_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the zigzag scanner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
        --top-module zz_scan_tb \
        -Mdir obj_dir \
        -f project.f
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

out=$(./obj_dir/Vzz_scan_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$out" | grep -q -x -F "Result: PASSED"; then
        exit 0
else
        echo "Pass message not found in simulation output"
        exit 1
fi

/* testbench/zz_scan_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zz_cfg.svh"

module zz_scan_tb;

        typedef logic [`ZZ_COEF_W-1:0] val_t;

        localparam int drain_limit = 100;  // Cycles from the last row to the last output
        localparam int mark_limit  = 20;

        // Raster position (row*8 + col) of each scan position
        localparam int scan_order [64] = '{
                 0,  1,  8, 16,  9,  2,  3, 10,
                17, 24, 32, 25, 18, 11,  4,  5,
                12, 19, 26, 33, 40, 48, 41, 34,
                27, 20, 13,  6,  7, 14, 21, 28,
                35, 42, 49, 56, 57, 50, 43, 36,
                29, 22, 15, 23, 30, 37, 44, 51,
                58, 59, 52, 45, 38, 31, 39, 46,
                53, 60, 61, 54, 47, 55, 62, 63
        };

        logic clk = 1'b0;
        logic nrst;
        logic valid;
        val_t coef [8];
        val_t zz_coef;
        logic vlc_en;

        int   cyc = 0;
        val_t blk [64];             // Block under test in row-major order

        val_t exp_q [$];            // Expected enabled outputs of all blocks
        int   len_q [$];            // Stream length per block
        int   acc_q [$];            // Cycle count after the accepted valid edge
        int   blocks_sent = 0;

        int   marks_seen = 0;
        int   pos = 0;
        int   cur_len = 0;
        int   start_cyc = 0;
        val_t exp_val;
        bit   expect_mark = 1'b0;

        zz_scan_top u_dut (
                .clk       (clk),
                .nrst      (nrst),
                .valid_i   (valid),
                .coef0_i   (coef[0]),
                .coef1_i   (coef[1]),
                .coef2_i   (coef[2]),
                .coef3_i   (coef[3]),
                .coef4_i   (coef[4]),
                .coef5_i   (coef[5]),
                .coef6_i   (coef[6]),
                .coef7_i   (coef[7]),
                .zz_coef_o (zz_coef),
                .vlc_en_o  (vlc_en)
        );

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cyc <= cyc + 1;
        end

        task automatic stop_failed();
                $display("Result: FAILED");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string what, input int expv, input int got);
                $display("[ERROR] %0t ns: %s, expected 0x%0h, got 0x%0h", $time, what, expv, got);
                stop_failed();
        endtask

        task automatic abort_run(input string why);
                $display("%s (at %0t ns)", why, $time);
                stop_failed();
        endtask

        // Fills the expected stream in scan order and returns the last nonzero position
        function automatic int ref_scan(input val_t b [64], output val_t s [64]);
                int last;
                last = 0;
                for (int k = 0; k < 64; k++) begin
                        s[k] = b[scan_order[k]];
                        if (s[k] != '0) begin
                                last = k;
                        end
                end
                return last;
        endfunction

        task automatic make_dense();
                for (int i = 0; i < 64; i++) begin
                        blk[i] = val_t'(1 + $urandom % 255);
                end
        endtask

        task automatic make_sparse();
                int p;
                p = int'($urandom % 64);
                for (int i = 0; i < 64; i++) begin
                        blk[i] = '0;
                end
                for (int k = 0; k < p; k++) begin
                        if ($urandom % 4 == 0) begin
                                blk[scan_order[k]] = val_t'(1 + $urandom % 255);
                        end
                end
                blk[scan_order[p]] = val_t'(1 + $urandom % 255);  // Forced last nonzero
        endtask

        task automatic make_zero();
                for (int i = 0; i < 64; i++) begin
                        blk[i] = '0;
                end
        endtask

        task automatic put_row(input int r);
                for (int c = 0; c < 8; c++) begin
                        coef[c] <= blk[r*8 + c];
                end
        endtask

        task automatic put_noise();
                for (int c = 0; c < 8; c++) begin
                        coef[c] <= val_t'($urandom);
                end
        endtask

        // Starts on the edge before acceptance and returns after the last enabled output
        task automatic run_block(input bit extra);
                val_t stream [64];
                int   last;
                int   seen;
                int   waited;
                last = ref_scan(blk, stream);
                for (int k = 0; k <= last; k++) begin
                        exp_q.push_back(stream[k]);
                end
                len_q.push_back(last + 1);
                blocks_sent++;
                @(posedge clk);
                valid <= 1'b1;
                for (int r = 0; r < 8; r++) begin
                        @(posedge clk);
                        if (r == 0) begin
                                acc_q.push_back(cyc + 1);  // Edge E0
                        end
                        put_row(r);
                        valid <= extra && (r % 2 == 1);  // Pulses while loading
                end
                seen = 0;
                waited = 0;
                while (seen < last + 1) begin
                        @(posedge clk);
                        put_noise();
                        valid <= extra && ($urandom % 3 == 0);
                        @(negedge clk);
                        if (vlc_en) begin
                                seen++;
                        end
                        waited++;
                        if (waited > drain_limit) begin
                                abort_run("Timeout: the block stream never finished");
                        end
                end
        endtask

        task automatic idle_gap(input int n);
                repeat (n) begin
                        @(posedge clk);
                        valid <= 1'b0;
                end
        endtask

        // Output checks sampled away from the driving edge
        always @(negedge clk) begin
                if (nrst) begin
                        if (expect_mark) begin
                                assert (vlc_en == 1'b0)
                                else report_mismatch("enable in marker cycle", 0, int'(vlc_en));
                                assert (zz_coef == `ZZ_END_MARK)
                                else report_mismatch("end marker", `ZZ_END_MARK, int'(zz_coef));
                                expect_mark = 1'b0;
                                marks_seen++;
                        end else if (vlc_en) begin
                                assert (exp_q.size() > 0)
                                else abort_run("Enable went high with no block outstanding");
                                if (pos == 0) begin
                                        start_cyc = acc_q.pop_front();
                                        cur_len = len_q.pop_front();
                                        assert (cyc - start_cyc == 9)
                                        else report_mismatch("first output latency",
                                                             9, cyc - start_cyc);
                                end
                                exp_val = exp_q.pop_front();
                                assert (zz_coef == exp_val)
                                else report_mismatch($sformatf("scan position %0d", pos),
                                                     int'(exp_val), int'(zz_coef));
                                pos++;
                                if (pos == cur_len) begin
                                        pos = 0;
                                        expect_mark = 1'b1;
                                end
                        end else begin
                                assert (pos == 0)
                                else report_mismatch("enabled outputs in block", cur_len, pos);
                        end
                end
        end

        initial begin
                int waited;
                void'($urandom(8));
                nrst <= 1'b0;
                valid <= 1'b0;
                for (int c = 0; c < 8; c++) begin
                        coef[c] <= '0;
                end
                repeat (10) @(posedge clk);
                nrst <= 1'b1;

                for (int i = 0; i < 8; i++) begin
                        @(negedge clk);
                        assert (vlc_en == 1'b0)
                        else report_mismatch("enable while idle after reset", 0, int'(vlc_en));
                        assert (zz_coef == '0)
                        else report_mismatch("output while idle after reset", 0, int'(zz_coef));
                end

                make_dense();
                run_block(1'b0);
                idle_gap(4);

                repeat (12) begin
                        make_sparse();
                        run_block(1'b0);
                        idle_gap(3);
                end

                make_zero();
                run_block(1'b0);
                idle_gap(4);

                // Back-to-back blocks with the next valid driven on the marker edge
                for (int b = 0; b < 9; b++) begin
                        case (b % 3)
                        0: make_dense();
                        1: make_sparse();
                        default: make_zero();
                        endcase
                        run_block(1'b1);
                end

                waited = 0;
                while (marks_seen != blocks_sent) begin
                        @(posedge clk);
                        valid <= 1'b0;
                        waited++;
                        if (waited > mark_limit) begin
                                abort_run("Timeout: end marker of the last block never came");
                        end
                end
                repeat (4) @(posedge clk);
                $display("Result: PASSED");
                $finish;
        end

endmodule

`default_nettype wire

/* logic/zz_scan_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "zz_cfg.svh"

module zz_scan_top (
        input  logic                  clk,
        input  logic                  nrst,
        input  logic                  valid_i,
        input  logic [`ZZ_COEF_W-1:0] coef0_i,
        input  logic [`ZZ_COEF_W-1:0] coef1_i,
        input  logic [`ZZ_COEF_W-1:0] coef2_i,
        input  logic [`ZZ_COEF_W-1:0] coef3_i,
        input  logic [`ZZ_COEF_W-1:0] coef4_i,
        input  logic [`ZZ_COEF_W-1:0] coef5_i,
        input  logic [`ZZ_COEF_W-1:0] coef6_i,
        input  logic [`ZZ_COEF_W-1:0] coef7_i,
        output logic [`ZZ_COEF_W-1:0] zz_coef_o,
        output logic                  vlc_en_o
);
        import zz_pkg::*;

        zz_idx_t rd_addr;
        coef_t   rd_data;
        zz_idx_t last_idx;

        zz_row_if row_bus ();

        // Input columns straight onto the row bus
        assign row_bus.coef[0] = coef0_i;
        assign row_bus.coef[1] = coef1_i;
        assign row_bus.coef[2] = coef2_i;
        assign row_bus.coef[3] = coef3_i;
        assign row_bus.coef[4] = coef4_i;
        assign row_bus.coef[5] = coef5_i;
        assign row_bus.coef[6] = coef6_i;
        assign row_bus.coef[7] = coef7_i;

        zz_coef_store u_store (
                .clk       (clk),
                .nrst      (nrst),
                .row_bus   (row_bus),
                .rd_addr_i (rd_addr),
                .rd_data_o (rd_data)
        );

        zz_last_tracker u_tracker (
                .clk        (clk),
                .nrst       (nrst),
                .row_bus    (row_bus),
                .last_idx_o (last_idx)
        );

        zz_scan_seq u_seq (
                .clk        (clk),
                .nrst       (nrst),
                .valid_i    (valid_i),
                .row_bus    (row_bus),
                .rd_addr_o  (rd_addr),
                .rd_data_i  (rd_data),
                .last_idx_i (last_idx),
                .zz_coef_o  (zz_coef_o),
                .vlc_en_o   (vlc_en_o)
        );

endmodule

`default_nettype wire

/* logic/zz_scan_seq.sv */
`default_nettype none
`timescale 1ns/1ps

`include "zz_cfg.svh"

module zz_scan_seq (
        input  logic             clk,
        input  logic             nrst,
        input  logic             valid_i,
        zz_row_if.seq            row_bus,
        output zz_pkg::zz_idx_t  rd_addr_o,
        input  zz_pkg::coef_t    rd_data_i,
        input  zz_pkg::zz_idx_t  last_idx_i,
        output zz_pkg::coef_t    zz_coef_o,
        output logic             vlc_en_o
);
        import zz_pkg::*;

        scan_state_t state;
        row_idx_t    row_cnt;
        zz_idx_t     rd_ptr;

        always_ff @(posedge clk or negedge nrst) begin
                if (!nrst) begin
                        state     <= ST_IDLE;
                        row_cnt   <= '0;
                        rd_ptr    <= '0;
                        zz_coef_o <= '0;
                        vlc_en_o  <= 1'b0;
                end else begin
                        case (state)
                        ST_IDLE: begin
                                zz_coef_o <= '0;
                                vlc_en_o  <= 1'b0;
                                if (valid_i) begin
                                        state   <= ST_LOAD;
                                        row_cnt <= '0;
                                        rd_ptr  <= '0;
                                end
                        end

                        // One row per cycle, load stays high throughout
                        ST_LOAD: begin
                                row_cnt <= row_cnt + 1'b1;
                                if (row_cnt == row_idx_t'(`ZZ_N - 1)) begin
                                        state <= ST_DRAIN;
                                end
                        end

                        // Last index is final here, the last row went in
                        ST_DRAIN: begin
                                zz_coef_o <= rd_data_i;
                                vlc_en_o  <= 1'b1;
                                rd_ptr    <= rd_ptr + 1'b1;
                                if (rd_ptr == last_idx_i) begin
                                        state <= ST_MARK;
                                end
                        end

                        ST_MARK: begin
                                zz_coef_o <= `ZZ_END_MARK;
                                vlc_en_o  <= 1'b0;
                                state     <= ST_IDLE;
                        end

                        default: begin
                                state <= ST_IDLE;
                        end
                        endcase
                end
        end

        assign row_bus.load = (state == ST_LOAD);
        assign row_bus.row  = row_cnt;
        assign rd_addr_o    = rd_ptr;

endmodule

`default_nettype wire

/* logic/zz_last_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

`include "zz_cfg.svh"

module zz_last_tracker (
        input  logic             clk,
        input  logic             nrst,
        zz_row_if.tracker        row_bus,
        output zz_pkg::zz_idx_t  last_idx_o
);
        import zz_pkg::*;

        logic [2:0] hi_col;
        logic       row_nz;
        zz_idx_t    row_last;
        zz_idx_t    last_q;

        // Highest nonzero column of the incoming row
        always_comb begin
                hi_col = 3'd0;
                row_nz = 1'b0;
                for (int c = 0; c < `ZZ_N; c++) begin
                        if (row_bus.coef[c] != '0) begin
                                hi_col = 3'(c);
                                row_nz = 1'b1;
                        end
                end
        end

        // Highest column is also the row's highest scan position
        assign row_last = zz_index(row_bus.row, hi_col);

        always_ff @(posedge clk or negedge nrst) begin
                if (!nrst) begin
                        last_q <= '0;
                end else if (row_bus.load) begin
                        if (row_bus.row == '0) begin
                                last_q <= row_nz ? row_last : '0;  // New block
                        end else if (row_nz && (row_last > last_q)) begin
                                last_q <= row_last;
                        end
                end
        end

        assign last_idx_o = last_q;

endmodule

`default_nettype wire

/* logic/zz_coef_store.sv */
`default_nettype none
`timescale 1ns/1ps

`include "zz_cfg.svh"

module zz_coef_store (
        input  logic             clk,
        input  logic             nrst,
        zz_row_if.store          row_bus,
        input  zz_pkg::zz_idx_t  rd_addr_i,
        output zz_pkg::coef_t    rd_data_o
);
        import zz_pkg::*;

        // Held in scan order, so the drain reads it linearly
        coef_t mem [`ZZ_N*`ZZ_N];

        // Whole row in one edge, one entry per column
        always_ff @(posedge clk) begin
                if (nrst && row_bus.load) begin
                        for (int c = 0; c < `ZZ_N; c++) begin
                                mem[zz_index(row_bus.row, 3'(c))] <= row_bus.coef[c];
                        end
                end
        end

        assign rd_data_o = mem[rd_addr_i];  // Same-cycle read

endmodule

`default_nettype wire

/* logic/zz_row_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "zz_cfg.svh"

interface zz_row_if;
        import zz_pkg::*;

        logic     load;          // Row taken at this edge
        row_idx_t row;
        coef_t    coef [`ZZ_N];  // Column 0 first

        modport seq (
                output load,
                output row
        );

        modport store (
                input load,
                input row,
                input coef
        );

        modport tracker (
                input load,
                input row,
                input coef
        );
endinterface

`default_nettype wire

/* logic/zz_pkg.sv */
`default_nettype none

`include "zz_cfg.svh"

package zz_pkg;

        typedef logic [`ZZ_COEF_W-1:0] coef_t;
        typedef logic [5:0]            zz_idx_t;  // Position in scan order
        typedef logic [2:0]            row_idx_t;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_LOAD,
                ST_DRAIN,
                ST_MARK
        } scan_state_t;

        // JPEG zigzag order, indexed by {row, col}
        localparam zz_idx_t ZZ_TABLE [64] = '{
                 0,  1,  5,  6, 14, 15, 27, 28,
                 2,  4,  7, 13, 16, 26, 29, 42,
                 3,  8, 12, 17, 25, 30, 41, 43,
                 9, 11, 18, 24, 31, 40, 44, 53,
                10, 19, 23, 32, 39, 45, 52, 54,
                20, 22, 33, 38, 46, 51, 55, 60,
                21, 34, 37, 47, 50, 56, 59, 61,
                35, 36, 48, 49, 57, 58, 62, 63
        };

        // Rises with col inside every row
        function automatic zz_idx_t zz_index(input row_idx_t row, input logic [2:0] col);
                return ZZ_TABLE[{row, col}];
        endfunction

endpackage

`default_nettype wire

/* include/zz_cfg.svh */
`ifndef ZZ_CFG_SVH
`define ZZ_CFG_SVH

// Block side, the scan order is fixed to 8x8
`define ZZ_N 8

// Quantized coefficient width
`define ZZ_COEF_W 8

// End-of-block marker, all ones
`define ZZ_END_MARK {`ZZ_COEF_W{1'b1}}

`endif
